// File: vlog.f
+incdir+design
design/rp_sample_pkg.sv
design/rp_cfg_pkg.sv
design/rp_cfg_if.sv
design/rp_calib_regs.sv
design/rp_adc_frontend.sv
design/rp_linear.sv
design/rp_dac_output.sv
design/rp_analog_top.sv
tb/rp_analog_properties.sv
tb/rp_analog_tb.sv

// File: Bender.yml
package:
  name: rp_analog

sources:
  - include_dirs:
      - design
    files:
      - design/rp_sample_pkg.sv
      - design/rp_cfg_pkg.sv
      - design/rp_cfg_if.sv
      - design/rp_calib_regs.sv
      - design/rp_adc_frontend.sv
      - design/rp_linear.sv
      - design/rp_dac_output.sv
      - design/rp_analog_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/rp_analog_properties.sv
      - tb/rp_analog_tb.sv

// File: tb/rp_analog_tb.sv
/*
 * directed testbench for the analog signal path
 * clock, reset, register model, reference model, compare tasks
 */
`timescale 1ns/1ns
`include "rp_settings.svh"

module rp_analog_tb;
  import rp_sample_pkg::*;
  import rp_cfg_pkg::*;

  // well above the summed length of the directed tests
  localparam int MAX_CYCLES = 2000;
  // bits inverted by the offset-binary conversion
  localparam raw_word_t LOW_MASK = {1'b0, {(`RP_SW-1){1'b1}}};
  localparam adc_sample_t ADC_MAX = {1'b0, {(`RP_SW-1){1'b1}}};
  localparam adc_sample_t ADC_MIN = {1'b1, {(`RP_SW-1){1'b0}}};

  logic                      adc_clk;
  logic                      top_rst;
  raw_word_t   [`RP_CHN-1:0] adc_dat_i;
  logic                      cfg_we_i;
  cfg_addr_t                 cfg_addr_i;
  cfg_data_t                 cfg_wdata_i;
  dac_sample_t [`RP_CHN-1:0] gen_dat_i;
  logic                      gen_vld_i;
  adc_sample_t [`RP_CHN-1:0] osc_dat_o;
  logic                      osc_vld_o;
  raw_word_t                 dac_dat_o;
  logic                      dac_sel_o;
  logic                      dac_rst_o;

  // expected calibration register contents
  gain_t   [`RP_CHN-1:0] adc_gain_m;
  gain_t   [`RP_CHN-1:0] dac_gain_m;
  offset_t [`RP_CHN-1:0] adc_offs_m;
  offset_t [`RP_CHN-1:0] dac_offs_m;

  int checks;
  int errors;
  int cycles;

  rp_analog_top rp_analog_top_i (.*);

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // pin word to signed by inverting all but the msb
  function automatic adc_sample_t from_raw(input raw_word_t w);
    return adc_sample_t'(w ^ LOW_MASK);
  endfunction

  function automatic raw_word_t to_raw(input dac_sample_t s);
    return raw_word_t'(s) ^ LOW_MASK;
  endfunction

  // product then floor shift by the fraction bits, offset and clip
  function automatic adc_sample_t calib(input logic signed [`RP_SW-1:0] s,
                                        input gain_t g, input offset_t o);
    longint v;
    longint lim;
    lim = longint'(1) << (`RP_SW - 1);
    v = (longint'(s) * longint'(g)) >>> `RP_GF;
    v = v + longint'(o);
    if (v > lim - 1)
      v = lim - 1;
    else if (v < -lim)
      v = -lim;
    return adc_sample_t'(v);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drive and compare helpers
  //////////////////////////////////////////////////////////////////////

  // step to 1 ns after the next rising edge where outputs have settled
  task automatic next_cycle();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic compare_adc(input adc_sample_t got, input adc_sample_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_dac(input raw_word_t got, input raw_word_t exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // one write strobe and model update plus one more cycle until the path sees it
  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    next_cycle();
    cfg_we_i = 1'b0;
    case (addr)
      adc_gain0: adc_gain_m[0] = gain_t'(data);
      adc_gain1: adc_gain_m[1] = gain_t'(data);
      adc_offs0: adc_offs_m[0] = offset_t'(data[`RP_SW-1:0]);
      adc_offs1: adc_offs_m[1] = offset_t'(data[`RP_SW-1:0]);
      dac_gain0: dac_gain_m[0] = gain_t'(data);
      dac_gain1: dac_gain_m[1] = gain_t'(data);
      dac_offs0: dac_offs_m[0] = offset_t'(data[`RP_SW-1:0]);
      dac_offs1: dac_offs_m[1] = offset_t'(data[`RP_SW-1:0]);
      default: ;
    endcase
    next_cycle();
  endtask

  // a word per cycle on both channels and each checked 3 cycles later
  task automatic adc_burst(input int n, input bit extremes);
    raw_word_t   [`RP_CHN-1:0] w;
    adc_sample_t [`RP_CHN-1:0] e;
    adc_sample_t [`RP_CHN-1:0] exp_q[$];
    for (int i = 0; i < n + 3; i++) begin
      if (i >= 3) begin
        e = exp_q.pop_front();
        compare_bit(osc_vld_o, 1'b1, "osc_vld_o");
        for (int c = 0; c < `RP_CHN; c++)
          compare_adc(osc_dat_o[c], e[c], $sformatf("osc_dat_o[%0d]", c));
      end
      if (i < n) begin
        for (int c = 0; c < `RP_CHN; c++) begin
          // full scale words that a gain near 2 drives into the clip
          if (extremes) begin
            w[c] = ((i + c) % 2) ? {`RP_SW{1'b1}} : '0;
            e[c] = ((i + c) % 2) ? ADC_MIN : ADC_MAX;
          end else begin
            w[c] = raw_word_t'($urandom());
            e[c] = calib(from_raw(w[c]), adc_gain_m[c], adc_offs_m[c]);
          end
        end
        adc_dat_i = w;
        exp_q.push_back(e);
      end
      next_cycle();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    compare_bit(osc_vld_o, 1'b0, "osc_vld_o");
    compare_bit(dac_sel_o, 1'b0, "dac_sel_o");
    compare_bit(dac_rst_o, 1'b1, "dac_rst_o");
    compare_dac(dac_dat_o, '0, "dac_dat_o");
    next_cycle();
    compare_bit(dac_rst_o, 1'b0, "dac_rst_o");
    compare_bit(dac_sel_o, 1'b1, "dac_sel_o");
  endtask

  task automatic test_adc_calib();
    cfg_write(adc_gain1, 16'h2000);
    cfg_write(adc_offs1, 16'd100);
    adc_burst(20, 1'b0);
    cfg_write(adc_gain0, 16'h7FFF);
    cfg_write(adc_gain1, 16'h7FFF);
    cfg_write(adc_offs1, 16'd0);
    adc_burst(8, 1'b1);
  endtask

  task automatic test_dac();
    dac_sample_t [`RP_CHN-1:0] g;
    raw_word_t   [`RP_CHN-1:0] exp_w;
    cfg_write(dac_gain0, 16'h3000);
    // -50
    cfg_write(dac_offs0, 16'hFFCE);
    cfg_write(dac_gain1, 16'h5000);
    cfg_write(dac_offs1, 16'd200);
    for (int c = 0; c < `RP_CHN; c++) begin
      g[c]     = dac_sample_t'($urandom());
      exp_w[c] = to_raw(calib(g[c], dac_gain_m[c], dac_offs_m[c]));
    end
    gen_dat_i = g;
    gen_vld_i = 1'b1;
    next_cycle();
    // data without valid must not reach the DAC
    gen_vld_i = 1'b0;
    gen_dat_i = ~g;
    repeat (3) next_cycle();
    for (int i = 0; i < 8; i++) begin
      if (dac_sel_o)
        compare_dac(dac_dat_o, exp_w[0], "dac_dat_o ch0");
      else
        compare_dac(dac_dat_o, exp_w[1], "dac_dat_o ch1");
      next_cycle();
    end
  endtask

  task automatic test_loopback();
    dac_sample_t [`RP_CHN-1:0] g;
    adc_sample_t [`RP_CHN-1:0] e;
    cfg_write(adc_gain0, 16'h3000);
    cfg_write(adc_gain1, 16'h4000);
    // -20
    cfg_write(adc_offs0, 16'hFFEC);
    cfg_write(adc_offs1, 16'd10);
    cfg_write(loop, 16'h0003);
    for (int c = 0; c < `RP_CHN; c++) begin
      g[c] = dac_sample_t'($urandom());
      e[c] = calib(calib(g[c], dac_gain_m[c], dac_offs_m[c]), adc_gain_m[c], adc_offs_m[c]);
    end
    gen_dat_i = g;
    gen_vld_i = 1'b1;
    adc_dat_i = {raw_word_t'($urandom()), raw_word_t'($urandom())};
    next_cycle();
    gen_vld_i = 1'b0;
    gen_dat_i = ~g;
    adc_dat_i = {raw_word_t'($urandom()), raw_word_t'($urandom())};
    repeat (2) next_cycle();
    compare_bit(osc_vld_o, 1'b0, "osc_vld_o");
    next_cycle();
    // 4 cycles after gen_vld_i
    compare_bit(osc_vld_o, 1'b1, "osc_vld_o");
    for (int c = 0; c < `RP_CHN; c++)
      compare_adc(osc_dat_o[c], e[c], $sformatf("osc_dat_o[%0d]", c));
    next_cycle();
    compare_bit(osc_vld_o, 1'b0, "osc_vld_o");
    // back to the ADC pins
    cfg_write(loop, 16'h0000);
    adc_burst(10, 1'b0);
  endtask

  task automatic test_done(input string name, input int err_start);
    $display("%0t ns: %s finished, %0d errors", $time, name, errors - err_start);
  endtask

  initial begin
    int err_start;
    void'($urandom(32'ha0f8_ed18));
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = loop;
    cfg_wdata_i = '0;
    gen_dat_i   = '0;
    gen_vld_i   = 1'b0;
    adc_gain_m  = {`RP_CHN{gain_t'(GAIN_UNITY)}};
    dac_gain_m  = {`RP_CHN{gain_t'(GAIN_UNITY)}};
    adc_offs_m  = '0;
    dac_offs_m  = '0;
    repeat (3) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    err_start = errors;
    test_reset();
    test_done("reset state", err_start);
    err_start = errors;
    adc_burst(20, 1'b0);
    test_done("unity ADC path", err_start);
    err_start = errors;
    test_adc_calib();
    test_done("ADC gain, offset and clip", err_start);
    err_start = errors;
    test_dac();
    test_done("DAC calibration and interleave", err_start);
    err_start = errors;
    test_loopback();
    test_done("loopback", err_start);

    // assertion failures from the bound checker
    errors += rp_analog_top_i.rp_analog_properties_i.fail_cnt;
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: tb/rp_analog_properties.sv
/*
 * concurrent checks on the analog top level
 * DAC select toggle, DAC reset, ADC valid level
 */
`timescale 1ns/1ns

module rp_analog_properties (
  input logic adc_clk,
  input logic top_rst,
  input logic osc_vld_i,
  input logic dac_sel_i,
  input logic dac_rst_i
);

  // failed assertions so far
  int fail_cnt = 0;

  // select alternates on every edge after the first one out of reset
  sel_toggle: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> (dac_sel_i != $past(dac_sel_i))
  ) else begin
    fail_cnt++;
    $error("dac_sel_o kept its value over two cycles");
  end

  // DAC reset spans top_rst and the edge after it
  rst_follow: assert property (
    @(posedge adc_clk) $past(top_rst) |-> dac_rst_i
  ) else begin
    fail_cnt++;
    $error("dac_rst_o low while top_rst was high");
  end

  // strobe must be a clean level
  vld_known: assert property (
    @(posedge adc_clk) disable iff (top_rst) !$isunknown(osc_vld_i)
  ) else begin
    fail_cnt++;
    $error("osc_vld_o unknown after reset");
  end

endmodule

bind rp_analog_top rp_analog_properties rp_analog_properties_i (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .osc_vld_i (osc_vld_o),
  .dac_sel_i (dac_sel_o),
  .dac_rst_i (dac_rst_o)
);

// File: design/rp_analog_top.sv
/*
 * analog signal path top level
 * calibration registers, two ADC and two DAC channels
 */
`timescale 1ns/1ns
`include "rp_settings.svh"

module rp_analog_top (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // ADC pins, offset binary
  input  rp_sample_pkg::raw_word_t   [`RP_CHN-1:0] adc_dat_i,
  // calibration register writes
  input  logic                                    cfg_we_i,
  input  rp_cfg_pkg::cfg_addr_t                    cfg_addr_i,
  input  rp_cfg_pkg::cfg_data_t                    cfg_wdata_i,
  // generator samples
  input  rp_sample_pkg::dac_sample_t [`RP_CHN-1:0] gen_dat_i,
  input  logic                                    gen_vld_i,
  // calibrated ADC samples toward acquisition
  output rp_sample_pkg::adc_sample_t [`RP_CHN-1:0] osc_dat_o,
  output logic                                    osc_vld_o,
  // DAC pins
  output rp_sample_pkg::raw_word_t                 dac_dat_o,
  output logic                                    dac_sel_o,
  output logic                                    dac_rst_o
);
  import rp_sample_pkg::*;

  // frontend output, before ADC calibration
  adc_sample_t [`RP_CHN-1:0] adc_dat;
  logic        [`RP_CHN-1:0] adc_vld;
  logic        [`RP_CHN-1:0] osc_vld;
  // calibrated DAC stream
  dac_sample_t [`RP_CHN-1:0] dac_dat;
  logic        [`RP_CHN-1:0] dac_vld;

  rp_cfg_if cfg_bus ();

  rp_calib_regs rp_calib_regs_i (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg         (cfg_bus)
  );

  //////////////////////////////////////////////////////////////////////
  // per channel ADC and DAC paths
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn

    rp_adc_frontend #(.CH (i)) rp_adc_frontend_i (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .adc_dat_i  (adc_dat_i[i]),
      .loop_dat_i (dac_dat[i]),
      .loop_vld_i (dac_vld[i]),
      .cfg        (cfg_bus),
      .dat_o      (adc_dat[i]),
      .vld_o      (adc_vld[i])
    );

    rp_linear #(.sample_t (adc_sample_t)) rp_linear_adc_i (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (adc_dat[i]),
      .vld_i   (adc_vld[i]),
      .gain_i  (cfg_bus.adc_gain[i]),
      .offs_i  (cfg_bus.adc_offs[i]),
      .dat_o   (osc_dat_o[i]),
      .vld_o   (osc_vld[i])
    );

    rp_linear #(.sample_t (dac_sample_t)) rp_linear_dac_i (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (gen_dat_i[i]),
      .vld_i   (gen_vld_i),
      .gain_i  (cfg_bus.dac_gain[i]),
      .offs_i  (cfg_bus.dac_offs[i]),
      .dat_o   (dac_dat[i]),
      .vld_o   (dac_vld[i])
    );

  end

  // channels run in lockstep, channel 0 stands for both
  assign osc_vld_o = osc_vld[0];

  rp_dac_output rp_dac_output_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dat_i     (dac_dat),
    .vld_i     (dac_vld[0]),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

// File: design/rp_dac_output.sv
/*
 * DAC word conversion and two channel interleave
 * channel select toggle and registered DAC reset
 */
`timescale 1ns/1ns
`include "rp_settings.svh"

module rp_dac_output (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  input  rp_sample_pkg::dac_sample_t [`RP_CHN-1:0] dat_i,
  input  logic                                    vld_i,
  output rp_sample_pkg::raw_word_t                 dac_dat_o,
  output logic                                    dac_sel_o,
  output logic                                    dac_rst_o
);
  import rp_sample_pkg::*;

  raw_word_t [`RP_CHN-1:0] hold_q;

  // newest calibrated word per channel, back to offset binary
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      hold_q <= '0;
    end else if (vld_i) begin
      for (int i = 0; i < `RP_CHN; i++) begin
        hold_q[i] <= {dat_i[i][`RP_SW-1], ~dat_i[i][`RP_SW-2:0]};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // interleave onto the single DAC bus
  //////////////////////////////////////////////////////////////////////

  // sel high carries channel 0, low carries channel 1
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      dac_sel_o <= ~dac_sel_o;
      // word matches the select value after this edge
      dac_dat_o <= ~dac_sel_o ? hold_q[0] : hold_q[1];
    end
  end

  // DAC reset, released on the first edge after top_rst
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

endmodule

// File: design/rp_linear.sv
/*
 * gain and offset calibration with saturation
 * two register stages, payload type set by parameter
 */
`timescale 1ns/1ns
`include "rp_settings.svh"

module rp_linear #(
  parameter type sample_t = logic signed [`RP_SW-1:0]
) (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  input  sample_t                dat_i,
  input  logic                   vld_i,
  input  rp_sample_pkg::gain_t   gain_i,
  input  rp_sample_pkg::offset_t offs_i,
  output sample_t                dat_o,
  output logic                   vld_o
);

  localparam int SW = $bits(sample_t);
  // full product width
  localparam int PW = SW + `RP_GW;
  // clip limits, one guard bit above the product
  localparam logic signed [PW:0] SMAX = {{(PW-SW+2){1'b0}}, {(SW-1){1'b1}}};
  localparam logic signed [PW:0] SMIN = ~SMAX;

  logic signed [PW-1:0] prod_q;
  logic signed [PW:0]   sum;
  logic                 vld_q;

  // stage one, full precision product
  always_ff @(posedge adc_clk) begin
    prod_q <= $signed(dat_i) * gain_i;
  end

  // drop fraction bits, add offset
  assign sum = (prod_q >>> `RP_GF) + offs_i;

  // stage two, clip to sample range
  always_ff @(posedge adc_clk) begin
    if (sum > SMAX) begin
      dat_o <= sample_t'(SMAX[SW-1:0]);
    end else if (sum < SMIN) begin
      dat_o <= sample_t'(SMIN[SW-1:0]);
    end else begin
      dat_o <= sample_t'(sum[SW-1:0]);
    end
  end

  // valid follows data through both stages
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_q <= 1'b0;
      vld_o <= 1'b0;
    end else begin
      vld_q <= vld_i;
      vld_o <= vld_q;
    end
  end

endmodule

// File: design/rp_adc_frontend.sv
/*
 * ADC input register and offset-binary to signed conversion
 * digital loopback select per channel
 */
`timescale 1ns/1ns
`include "rp_settings.svh"

module rp_adc_frontend #(
  parameter int CH = 0
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  rp_sample_pkg::raw_word_t   adc_dat_i,
  // calibrated DAC stream for loopback
  input  rp_sample_pkg::adc_sample_t loop_dat_i,
  input  logic                      loop_vld_i,
  rp_cfg_if.path                    cfg,
  output rp_sample_pkg::adc_sample_t dat_o,
  output logic                      vld_o
);
  import rp_sample_pkg::*;

  raw_word_t   raw_q;
  adc_sample_t adc_dat;
  logic        vld_q;

  // pin register, ideally packed into the IO cells
  always_ff @(posedge adc_clk) begin
    raw_q <= adc_dat_i;
  end

  // ADC delivers a sample every cycle once out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= 1'b1;
    end
  end

  // keep msb, invert the rest
  assign adc_dat = {raw_q[`RP_SW-1], ~raw_q[`RP_SW-2:0]};

  // loopback mux, combinational so loopback adds no delay
  assign dat_o = cfg.loop[CH] ? loop_dat_i : adc_dat;
  assign vld_o = cfg.loop[CH] ? loop_vld_i : vld_q;

endmodule

// File: design/rp_calib_regs.sv
/*
 * write-only calibration register file
 * gains, offsets and loopback bits for both directions
 */
`timescale 1ns/1ns
`include "rp_settings.svh"

module rp_calib_regs (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // write port
  input  logic                  cfg_we_i,
  input  rp_cfg_pkg::cfg_addr_t cfg_addr_i,
  input  rp_cfg_pkg::cfg_data_t cfg_wdata_i,
  // settings toward the signal path
  rp_cfg_if.regs                cfg
);
  import rp_cfg_pkg::*;
  import rp_sample_pkg::*;

  logic addr_ok;

  // addresses past the map are dropped
  assign addr_ok = (cfg_addr_i < 4'(`RP_REGS));

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cfg.loop <= '0;
      // unity gain, no offset
      for (int i = 0; i < `RP_CHN; i++) begin
        cfg.adc_gain[i] <= gain_t'(GAIN_UNITY);
        cfg.adc_offs[i] <= '0;
        cfg.dac_gain[i] <= gain_t'(GAIN_UNITY);
        cfg.dac_offs[i] <= '0;
      end
    end else if (cfg_we_i && addr_ok) begin
      case (cfg_addr_i)
        loop:      cfg.loop        <= cfg_wdata_i[`RP_CHN-1:0];
        adc_gain0: cfg.adc_gain[0] <= gain_t'(cfg_wdata_i);
        adc_gain1: cfg.adc_gain[1] <= gain_t'(cfg_wdata_i);
        // offsets keep the low sample-width bits, still two's complement
        adc_offs0: cfg.adc_offs[0] <= offset_t'(cfg_wdata_i[`RP_SW-1:0]);
        adc_offs1: cfg.adc_offs[1] <= offset_t'(cfg_wdata_i[`RP_SW-1:0]);
        dac_gain0: cfg.dac_gain[0] <= gain_t'(cfg_wdata_i);
        dac_gain1: cfg.dac_gain[1] <= gain_t'(cfg_wdata_i);
        dac_offs0: cfg.dac_offs[0] <= offset_t'(cfg_wdata_i[`RP_SW-1:0]);
        dac_offs1: cfg.dac_offs[1] <= offset_t'(cfg_wdata_i[`RP_SW-1:0]);
        default: ;
      endcase
    end
  end

endmodule

// File: design/rp_cfg_if.sv
/*
 * calibration and loopback settings bundle
 * regs side drives, path side reads
 */
`timescale 1ns/1ns
`include "rp_settings.svh"

interface rp_cfg_if;
  import rp_sample_pkg::*;

  // per channel calibration
  gain_t   [`RP_CHN-1:0] adc_gain;
  offset_t [`RP_CHN-1:0] adc_offs;
  gain_t   [`RP_CHN-1:0] dac_gain;
  offset_t [`RP_CHN-1:0] dac_offs;
  // digital loopback select, one bit per channel
  logic    [`RP_CHN-1:0] loop;

  modport regs (output adc_gain, adc_offs, dac_gain, dac_offs, loop);
  modport path (input  adc_gain, adc_offs, dac_gain, dac_offs, loop);

endinterface

// File: design/rp_cfg_pkg.sv
/*
 * calibration register map
 * address enumeration, write data type, reset values
 */
package rp_cfg_pkg;

  // register addresses
  typedef enum logic [3:0] {
    loop      = 4'd0,
    adc_gain0 = 4'd1,
    adc_gain1 = 4'd2,
    adc_offs0 = 4'd3,
    adc_offs1 = 4'd4,
    dac_gain0 = 4'd5,
    dac_gain1 = 4'd6,
    dac_offs0 = 4'd7,
    dac_offs1 = 4'd8
  } cfg_addr_t;

  // write data
  typedef logic [15:0] cfg_data_t;

  // gain register value after reset, 1.0
  localparam cfg_data_t GAIN_UNITY = 16'h4000;

endpackage

// File: design/rp_sample_pkg.sv
/*
 * sample types of the ADC and DAC directions
 * pin word, gain and offset types for calibration
 */
`include "rp_settings.svh"

package rp_sample_pkg;

  // signed sample after ADC conversion
  typedef logic signed [`RP_SW-1:0] adc_sample_t;

  // signed sample toward the DAC
  typedef logic signed [`RP_SW-1:0] dac_sample_t;

  // offset-binary word as seen on the pins
  typedef logic [`RP_SW-1:0] raw_word_t;

  // fixed point gain, 2**RP_GF means unity
  typedef logic signed [`RP_GW-1:0] gain_t;

  // offset added after the gain
  typedef logic signed [`RP_SW-1:0] offset_t;

endpackage

// File: design/rp_settings.svh
/*
 * sizes shared by the analog signal path
 * channel count, sample width, gain format, register count
 */
`ifndef RP_SETTINGS_SVH
`define RP_SETTINGS_SVH

// channels in each direction (ADC in, DAC out)
`define RP_CHN 2
// ADC and DAC sample width
`define RP_SW 14
// calibration gain width
`define RP_GW 16
// gain fraction bits, 2**RP_GF is unity
`define RP_GF 14
// calibration register count
`define RP_REGS 9

`endif
